// ==== usb_tx_top.f ====
usb_tx_pkg.sv
usb_crc16.sv
usb_bit_encoder.sv
usb_tx_packetizer.sv
usb_tx_top.sv
usb_tx_assertions.sv
tb_usb_tx_top.sv

// ==== Makefile ====
# Verilator build and run for the USB transmitter testbench
# Override any variable on the command line, e.g. make run LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_usb_tx_top
FILELIST  ?= usb_tx_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS    := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails on the fail message, a missing pass line or a nonzero exit
run: $(SIM_BIN)
	@./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TESTBENCH FAILED" $(LOG) || \
	   ! grep -q "TESTBENCH PASSED" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb_usb_tx_top.sv ====
// ****************************************
// Table-driven testbench for usb_tx_top at CLKS_PER_BIT 4
// Line decoder samples at mid-bit on the falling edge
// Payload bytes are answered from pay_mem on byte_req
// ****************************************

`default_nettype none
`timescale 1ns/100ps

module tb_usb_tx_top;

  import usb_tx_pkg::*;

  localparam int CLKS_PER_BIT = 4;
  localparam int MAX_LEN      = 64;
  localparam int LEN_W        = $clog2(MAX_LEN + 1);
  localparam int NUM_ROWS     = 7;
  localparam int WAIT_LIMIT   = 200;
  localparam int PKT_LIMIT    = 4000;
  localparam int FILL_RAND    = 0;
  localparam int FILL_ONES    = 1;
  localparam int FILL_COUNT   = 2;

  // One stimulus row and its expected line behavior
  typedef struct packed {
    pid_t pid;
    int   len;
    int   fill;
    int   exp_bytes;
    int   exp_reqs;
    int   min_stuff;
  } row_t;

  logic             tb_clk = 1'b0;
  logic             arst_n;
  logic             start;
  pid_t             pid;
  logic [LEN_W-1:0] len;
  logic [7:0]       data_byte = 8'h00;
  logic             byte_req;
  logic             busy;
  logic             done;
  logic             d_mode;
  logic             dplus_out;
  logic             dminus_out;

  row_t       rows [NUM_ROWS];
  logic [7:0] pay_mem [MAX_LEN];
  logic [7:0] exp_q [$];
  logic [7:0] rx_q [$];
  int         req_cnt = 0;
  int         req_base = 0;
  int         err_cnt = 0;
  int         timeout_cnt = 0;
  // Decoder state
  logic       prev_level;
  logic [7:0] bit_acc;
  int         ones_run;
  int         bit_num;
  int         stuff_cnt;

  usb_tx_top #(
    .CLKS_PER_BIT(CLKS_PER_BIT),
    .MAX_LEN     (MAX_LEN)
  ) dut0 (
    .tb_clk     (tb_clk),
    .arst_n     (arst_n),
    .start      (start),
    .pid        (pid),
    .len        (len),
    .data_byte  (data_byte),
    .byte_req   (byte_req),
    .busy       (busy),
    .done       (done),
    .d_mode     (d_mode),
    .dplus_out  (dplus_out),
    .dminus_out (dminus_out)
  );

  // 4 ns clock
  always #2 tb_clk = ~tb_clk;

  // Byte source answering byte_req one cycle later
  always @(posedge tb_clk) begin
    if (byte_req) begin
      if (req_cnt - req_base < MAX_LEN) data_byte <= pay_mem[req_cnt - req_base];
      req_cnt <= req_cnt + 1;
    end
  end

  task automatic check_value(input string name, input int got, input int exp);
    assert (got == exp) else begin
      err_cnt++;
      $display("ERR %0t ns %s got %0h exp %0h", $time, name, got, exp);
    end
  endtask

  task automatic report_timeout(input string what);
    timeout_cnt++;
    $display("Timeout at %0t ns while waiting for %s", $time, what);
  endtask

  task automatic fill_payload(input int mode);
    for (int k = 0; k < MAX_LEN; k++) begin
      case (mode)
        FILL_RAND: pay_mem[k] = 8'($urandom);
        FILL_ONES: pay_mem[k] = 8'hFF;
        default:   pay_mem[k] = 8'(k);
      endcase
    end
  endtask

  // ****************************************
  // Expected bytes from the packet rules
  // ****************************************
  task automatic build_expected(input row_t r);
    logic [15:0] crc_r;
    logic [15:0] poly_rev;
    exp_q.delete();
    exp_q.push_back(SYNC_BYTE);
    exp_q.push_back({~r.pid, r.pid});
    if ((r.pid == PID_DATA0) || (r.pid == PID_DATA1)) begin
      // Reflected register with bit 0 as the first bit on the line
      for (int i = 0; i < 16; i++) poly_rev[i] = CRC16_POLY[15 - i];
      crc_r = CRC16_INIT;
      for (int k = 0; k < r.len; k++) begin
        exp_q.push_back(pay_mem[k]);
        crc_r = crc_r ^ {8'h00, pay_mem[k]};
        for (int i = 0; i < 8; i++) begin
          crc_r = crc_r[0] ? ((crc_r >> 1) ^ poly_rev) : (crc_r >> 1);
        end
      end
      // Sent complemented
      exp_q.push_back(~crc_r[7:0]);
      exp_q.push_back(~crc_r[15:8]);
    end
  endtask

  // NRZI decode and unstuff one sampled bit
  task automatic decode_line_bit(input logic level);
    logic bit_val;
    bit_val    = (level == prev_level);
    prev_level = level;
    if (ones_run == STUFF_LIMIT) begin
      assert (!bit_val) else begin
        err_cnt++;
        $display("Seven ones in a row at %0t ns, stuffed zero missing", $time);
      end
      stuff_cnt++;
      ones_run = 0;
    end else begin
      ones_run = bit_val ? ones_run + 1 : 0;
      bit_acc  = {bit_val, bit_acc[7:1]};
      bit_num++;
      if (bit_num % 8 == 0) rx_q.push_back(bit_acc);
    end
  endtask

  // ****************************************
  // One packet, start to done
  // ****************************************
  task automatic run_row(input row_t r);
    int   guard;
    int   cyc;
    int   se0_cyc;
    int   j_cyc;
    logic finished;
    fill_payload(r.fill);
    build_expected(r);
    rx_q.delete();
    prev_level = 1'b1;
    bit_acc    = 8'h00;
    ones_run   = 0;
    bit_num    = 0;
    stuff_cnt  = 0;
    req_base   = req_cnt;
    @(posedge tb_clk);
    start <= 1'b1;
    pid   <= r.pid;
    len   <= LEN_W'(r.len);
    @(posedge tb_clk);
    start <= 1'b0;
    guard = 0;
    while (!d_mode && guard < WAIT_LIMIT) begin
      @(negedge tb_clk);
      guard++;
    end
    if (!d_mode) begin
      report_timeout("d_mode to rise");
      return;
    end
    // First negedge with d_mode high is cycle 0 of bit 0
    cyc      = 0;
    se0_cyc  = 0;
    j_cyc    = 0;
    finished = 1'b0;
    while (!finished && cyc < PKT_LIMIT) begin
      if (done) finished = 1'b1;
      else if (!dplus_out && !dminus_out) se0_cyc++;
      else if (se0_cyc > 0) j_cyc++;
      else if (cyc % CLKS_PER_BIT == CLKS_PER_BIT / 2) decode_line_bit(dplus_out);
      if (!finished) begin
        @(negedge tb_clk);
        cyc++;
      end
    end
    if (!finished) begin
      report_timeout("done after packet");
      return;
    end
    // EOP shape and release
    check_value("se0_cycles", se0_cyc, EOP_SE0_BITS * CLKS_PER_BIT);
    check_value("j_cycles", j_cyc, CLKS_PER_BIT);
    check_value("d_mode", int'(d_mode), 0);
    check_value("busy", int'(busy), 0);
    check_value("byte_req_count", req_cnt - req_base, r.exp_reqs);
    check_value("partial_bits", bit_num % 8, 0);
    check_value("rx_byte_count", rx_q.size(), r.exp_bytes);
    for (int k = 0; k < rx_q.size() && k < exp_q.size(); k++) begin
      check_value($sformatf("rx_byte[%0d]", k), int'(rx_q[k]), int'(exp_q[k]));
    end
    assert (stuff_cnt >= r.min_stuff) else begin
      err_cnt++;
      $display("Only %0d stuffed zeros seen, at least %0d needed", stuff_cnt, r.min_stuff);
    end
    // done is a single pulse
    @(negedge tb_clk);
    check_value("done", int'(done), 0);
    check_value("d_mode", int'(d_mode), 0);
  endtask

  initial begin
    void'($urandom(32'hed35_c8c0));
    arst_n = 1'b0;
    start  = 1'b0;
    pid    = PID_ACK;
    len    = '0;
    rows[0] = '{PID_DATA0, 64, FILL_RAND, 68, 64, 0};
    rows[1] = '{PID_DATA1, 8, FILL_ONES, 12, 8, 10};
    rows[2] = '{PID_DATA0, 16, FILL_COUNT, 20, 16, 0};
    // Handshakes ignore len
    rows[3] = '{PID_ACK, 5, FILL_COUNT, 2, 0, 0};
    rows[4] = '{PID_NAK, 0, FILL_RAND, 2, 0, 0};
    rows[5] = '{PID_STALL, 3, FILL_RAND, 2, 0, 0};
    rows[6] = '{PID_DATA1, 0, FILL_RAND, 4, 0, 0};
    repeat (4) @(posedge tb_clk);
    arst_n <= 1'b1;
    // Idle state after reset
    @(negedge tb_clk);
    check_value("d_mode", int'(d_mode), 0);
    check_value("busy", int'(busy), 0);
    check_value("byte_req", int'(byte_req), 0);
    check_value("done", int'(done), 0);
    check_value("dplus_out", int'(dplus_out), 1);
    check_value("dminus_out", int'(dminus_out), 0);
    for (int i = 0; i < NUM_ROWS; i++) begin
      if (timeout_cnt != 0) break;
      run_row(rows[i]);
    end
    $display("Summary: %0d check errors, %0d timeouts, %0d assertion failures",
             err_cnt, timeout_cnt, dut0.assert0.fail_cnt);
    if (err_cnt == 0 && timeout_cnt == 0 && dut0.assert0.fail_cnt == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== usb_tx_assertions.sv ====
// ****************************************
// Line and strobe rules for usb_tx_top
// Sampled on rising tb_clk, off during reset
// ****************************************

`default_nettype none
`timescale 1ns/100ps

module usb_tx_assertions (
  input logic tb_clk,
  input logic arst_n,
  input logic byte_req,
  input logic busy,
  input logic done,
  input logic dplus_out,
  input logic dminus_out
);

  // Failure count, read by the testbench
  int fail_cnt = 0;

  // At most one byte request per cycle pair
  assert property (@(posedge tb_clk) disable iff (!arst_n) byte_req |=> !byte_req)
    else begin
      fail_cnt++;
      $error("byte_req high on two consecutive cycles");
    end

  // Packet end releases busy in the same cycle
  assert property (@(posedge tb_clk) disable iff (!arst_n) done |-> $fell(busy))
    else begin
      fail_cnt++;
      $error("done without busy falling");
    end

  // SE1 is never a legal line state
  assert property (@(posedge tb_clk) disable iff (!arst_n) !(dplus_out && dminus_out))
    else begin
      fail_cnt++;
      $error("line in SE1 state");
    end

endmodule

bind usb_tx_top usb_tx_assertions assert0 (
  .tb_clk     (tb_clk),
  .arst_n     (arst_n),
  .byte_req   (byte_req),
  .busy       (busy),
  .done       (done),
  .dplus_out  (dplus_out),
  .dminus_out (dminus_out)
);

`default_nettype wire

// ==== usb_tx_top.sv ====
// ****************************************
// Full-speed USB packet transmitter
// Line is J when idle, d_mode high while driving
// data_byte must be valid the cycle after byte_req
// ****************************************

`default_nettype none
`timescale 1ns/100ps

module usb_tx_top #(
  parameter int CLKS_PER_BIT = 4,
  parameter int MAX_LEN      = 64
) (
  input  logic                           tb_clk,
  input  logic                           arst_n,
  input  logic                           start,
  input  usb_tx_pkg::pid_t               pid,
  input  logic [$clog2(MAX_LEN + 1)-1:0] len,
  input  logic [7:0]                     data_byte,
  output logic                           byte_req,
  output logic                           busy,
  output logic                           done,
  output logic                           d_mode,
  output logic                           dplus_out,
  output logic                           dminus_out
);

  // Packetizer to encoder
  logic        tx_bit;
  logic        tx_valid;
  logic        tx_eop;
  logic        bit_take;
  logic        eop_done;
  // Packetizer to CRC
  logic        crc_clear;
  logic        crc_shift;
  logic        crc_bit;
  logic [15:0] crc_value;

  usb_tx_packetizer #(
    .MAX_LEN(MAX_LEN)
  ) packetizer0 (
    .tb_clk    (tb_clk),
    .arst_n    (arst_n),
    .start     (start),
    .pid       (pid),
    .len       (len),
    .data_byte (data_byte),
    .bit_take  (bit_take),
    .eop_done  (eop_done),
    .crc_value (crc_value),
    .byte_req  (byte_req),
    .busy      (busy),
    .done      (done),
    .tx_bit    (tx_bit),
    .tx_valid  (tx_valid),
    .tx_eop    (tx_eop),
    .crc_clear (crc_clear),
    .crc_shift (crc_shift),
    .crc_bit   (crc_bit)
  );

  usb_crc16 crc0 (
    .tb_clk    (tb_clk),
    .arst_n    (arst_n),
    .crc_clear (crc_clear),
    .crc_shift (crc_shift),
    .crc_bit   (crc_bit),
    .crc_value (crc_value)
  );

  usb_bit_encoder #(
    .CLKS_PER_BIT(CLKS_PER_BIT)
  ) encoder0 (
    .tb_clk     (tb_clk),
    .arst_n     (arst_n),
    .tx_bit     (tx_bit),
    .tx_valid   (tx_valid),
    .tx_eop     (tx_eop),
    .bit_take   (bit_take),
    .eop_done   (eop_done),
    .d_mode     (d_mode),
    .dplus_out  (dplus_out),
    .dminus_out (dminus_out)
  );

endmodule

`default_nettype wire

// ==== usb_tx_packetizer.sv ====
// ****************************************
// Packet sequencer for SYNC, PID, payload, CRC16 and EOP
// len above MAX_LEN is not supported
// One byte is prefetched, data_byte is sampled the cycle after byte_req
// start is ignored while busy
// ****************************************

`default_nettype none
`timescale 1ns/100ps

module usb_tx_packetizer #(
  parameter int MAX_LEN = 64
) (
  input  logic                           tb_clk,
  input  logic                           arst_n,
  input  logic                           start,
  input  usb_tx_pkg::pid_t               pid,
  input  logic [$clog2(MAX_LEN + 1)-1:0] len,
  input  logic [7:0]                     data_byte,
  input  logic                           bit_take,
  input  logic                           eop_done,
  input  logic [15:0]                    crc_value,
  output logic                           byte_req,
  output logic                           busy,
  output logic                           done,
  output logic                           tx_bit,
  output logic                           tx_valid,
  output logic                           tx_eop,
  output logic                           crc_clear,
  output logic                           crc_shift,
  output logic                           crc_bit
);

  import usb_tx_pkg::*;

  localparam int LEN_W = $clog2(MAX_LEN + 1);

  typedef enum logic [2:0] {
    PH_IDLE,
    PH_SYNC,
    PH_PID,
    PH_PAYLOAD,
    PH_CRC,
    PH_EOP,
    PH_WAIT
  } phase_t;

  phase_t           phase;
  pid_t             pid_q;
  logic [3:0]       bit_cnt;
  logic [LEN_W-1:0] load_left;
  logic [LEN_W-1:0] fetch_left;
  logic             req_q;
  logic [7:0]       shift_reg;
  logic [7:0]       next_byte;
  logic             start_ok;
  logic             byte_end;
  logic             crc_end;
  logic             load_next;
  logic             issue_req;

  // ****************************************
  // Field boundaries
  // ****************************************
  assign start_ok  = start && (phase == PH_IDLE);
  assign byte_end  = bit_take && (bit_cnt == 4'd7) && (phase != PH_CRC);
  assign crc_end   = bit_take && (bit_cnt == 4'd15) && (phase == PH_CRC);
  // Next payload byte moves from the prefetch register
  assign load_next = byte_end && ((phase == PH_PID) || (phase == PH_PAYLOAD)) &&
                     (load_left != '0);
  // Prefetch at SYNC end and at each payload load
  assign issue_req = (((phase == PH_SYNC) && byte_end) || load_next) && (fetch_left != '0);

  // ****************************************
  // Outputs to encoder and CRC
  // ****************************************
  assign busy     = (phase != PH_IDLE);
  assign tx_valid = (phase != PH_IDLE) && (phase != PH_WAIT);
  assign tx_eop   = (phase == PH_EOP);
  // CRC goes out complemented, bit 15 first
  assign tx_bit   = (phase == PH_CRC) ? ~crc_value[4'd15 - bit_cnt] : shift_reg[0];

  assign crc_clear = start_ok;
  assign crc_shift = bit_take && (phase == PH_PAYLOAD);
  assign crc_bit   = shift_reg[0];

  // ****************************************
  // Phase machine
  // ****************************************
  always_ff @(posedge tb_clk or negedge arst_n) begin
    if (!arst_n) begin
      phase      <= PH_IDLE;
      bit_cnt    <= '0;
      load_left  <= '0;
      fetch_left <= '0;
      byte_req   <= 1'b0;
      req_q      <= 1'b0;
      done       <= 1'b0;
    end else begin
      byte_req <= 1'b0;
      done     <= 1'b0;
      req_q    <= byte_req;

      // Bit index within the current field
      if (bit_take) begin
        bit_cnt <= (byte_end || crc_end) ? 4'd0 : bit_cnt + 1'b1;
      end

      if (issue_req) begin
        byte_req   <= 1'b1;
        fetch_left <= fetch_left - 1'b1;
      end
      if (load_next) begin
        load_left <= load_left - 1'b1;
      end

      case (phase)
        PH_IDLE: begin
          if (start_ok) begin
            phase   <= PH_SYNC;
            bit_cnt <= '0;
            // Handshakes carry no payload
            load_left  <= pid_has_data(pid) ? len : '0;
            fetch_left <= pid_has_data(pid) ? len : '0;
          end
        end
        PH_SYNC: begin
          if (byte_end) phase <= PH_PID;
        end
        PH_PID: begin
          if (load_next) begin
            phase <= PH_PAYLOAD;
          end else if (byte_end) begin
            // Zero-length data still gets CRC
            if (pid_has_data(pid_q)) phase <= PH_CRC;
            else phase <= PH_EOP;
          end
        end
        PH_PAYLOAD: begin
          if (byte_end && (load_left == '0)) phase <= PH_CRC;
        end
        PH_CRC: begin
          if (crc_end) phase <= PH_EOP;
        end
        PH_EOP: begin
          // Encoder owns the line until eop_done
          if (bit_take) phase <= PH_WAIT;
        end
        PH_WAIT: begin
          if (eop_done) begin
            phase <= PH_IDLE;
            done  <= 1'b1;
          end
        end
        default: phase <= PH_IDLE;
      endcase
    end
  end

  // Byte datapath, shifted out LSB first
  always_ff @(posedge tb_clk) begin
    if (req_q) next_byte <= data_byte;
    if (start_ok) begin
      pid_q     <= pid;
      shift_reg <= SYNC_BYTE;
    end else if ((phase == PH_SYNC) && byte_end) begin
      // PID in low nibble, check bits in high nibble
      shift_reg <= {~pid_q, pid_q};
    end else if (load_next) begin
      shift_reg <= next_byte;
    end else if (bit_take) begin
      shift_reg <= {1'b0, shift_reg[7:1]};
    end
  end

endmodule

`default_nettype wire

// ==== usb_bit_encoder.sv ====
// ****************************************
// Line driver with bit timing, bit stuffing, NRZI and EOP
// CLKS_PER_BIT must be 2 or more
// tx_valid must stay high from the first bit to the EOP request
// A missing bit mid-packet drops the packet and returns to J
// ****************************************

`default_nettype none
`timescale 1ns/100ps

module usb_bit_encoder #(
  parameter int CLKS_PER_BIT = 4
) (
  input  logic tb_clk,
  input  logic arst_n,
  input  logic tx_bit,
  input  logic tx_valid,
  input  logic tx_eop,
  output logic bit_take,
  output logic eop_done,
  output logic d_mode,
  output logic dplus_out,
  output logic dminus_out
);

  import usb_tx_pkg::*;

  localparam int CNT_W = $clog2(CLKS_PER_BIT);

  typedef enum logic [1:0] {
    ENC_IDLE,
    ENC_DATA,
    ENC_SE0,
    ENC_J
  } enc_state_t;

  enc_state_t            state;
  logic [CNT_W-1:0]      clk_cnt;
  logic [ONES_CNT_W-1:0] ones_cnt;
  logic [SE0_CNT_W-1:0]  se0_cnt;
  logic                  bit_end;
  logic                  stuff_now;

  // Last clock of the current line bit
  assign bit_end = (state != ENC_IDLE) && (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));

  // Six ones sent, next bit is a stuffed zero
  assign stuff_now = (state == ENC_DATA) && bit_end &&
                     (ones_cnt == ONES_CNT_W'(STUFF_LIMIT));

  // Idle takes at once, data takes at the bit boundary
  assign bit_take = tx_valid && !stuff_now &&
                    ((state == ENC_IDLE) || ((state == ENC_DATA) && bit_end));

  // End of the J bit after SE0
  assign eop_done = (state == ENC_J) && bit_end;

  always_ff @(posedge tb_clk or negedge arst_n) begin
    if (!arst_n) begin
      state      <= ENC_IDLE;
      clk_cnt    <= '0;
      ones_cnt   <= '0;
      se0_cnt    <= '0;
      d_mode     <= 1'b0;
      dplus_out  <= 1'b1;
      dminus_out <= 1'b0;
    end else begin
      // Bit period counter, parked at zero in idle
      if ((state == ENC_IDLE) || bit_end) begin
        clk_cnt <= '0;
      end else begin
        clk_cnt <= clk_cnt + 1'b1;
      end

      if (stuff_now) begin
        // Stuffed zero toggles the line
        dplus_out  <= ~dplus_out;
        dminus_out <= ~dminus_out;
        ones_cnt   <= '0;
      end else if (bit_take && tx_eop) begin
        // Start of EOP, SE0
        state      <= ENC_SE0;
        se0_cnt    <= '0;
        ones_cnt   <= '0;
        d_mode     <= 1'b1;
        dplus_out  <= 1'b0;
        dminus_out <= 1'b0;
      end else if (bit_take) begin
        state  <= ENC_DATA;
        d_mode <= 1'b1;
        // NRZI, one holds and zero toggles
        if (tx_bit) begin
          ones_cnt <= ones_cnt + 1'b1;
        end else begin
          ones_cnt   <= '0;
          dplus_out  <= ~dplus_out;
          dminus_out <= ~dminus_out;
        end
      end else if (bit_end) begin
        case (state)
          ENC_DATA: begin
            // Starved mid-packet
            state      <= ENC_IDLE;
            d_mode     <= 1'b0;
            ones_cnt   <= '0;
            dplus_out  <= 1'b1;
            dminus_out <= 1'b0;
          end
          ENC_SE0: begin
            if (se0_cnt == SE0_CNT_W'(EOP_SE0_BITS - 1)) begin
              // SE0 done, one J bit follows
              state      <= ENC_J;
              dplus_out  <= 1'b1;
              dminus_out <= 1'b0;
            end else begin
              se0_cnt <= se0_cnt + 1'b1;
            end
          end
          ENC_J: begin
            // Release the line
            state  <= ENC_IDLE;
            d_mode <= 1'b0;
          end
          default: begin
          end
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// ==== usb_crc16.sv ====
// ****************************************
// Serial CRC16 over the payload, one bit per shift
// Bits must arrive LSB first within each byte
// Output is the raw register, the caller complements it
// ****************************************

`default_nettype none
`timescale 1ns/100ps

module usb_crc16 (
  input  logic        tb_clk,
  input  logic        arst_n,
  input  logic        crc_clear,
  input  logic        crc_shift,
  input  logic        crc_bit,
  output logic [15:0] crc_value
);

  import usb_tx_pkg::*;

  logic feedback;

  // Incoming bit against the register MSB
  assign feedback = crc_bit ^ crc_value[15];

  always_ff @(posedge tb_clk or negedge arst_n) begin
    if (!arst_n) begin
      crc_value <= CRC16_INIT;
    end else if (crc_clear) begin
      // New packet
      crc_value <= CRC16_INIT;
    end else if (crc_shift) begin
      // Shift left, fold in polynomial on feedback
      if (feedback) begin
        crc_value <= {crc_value[14:0], 1'b0} ^ CRC16_POLY;
      end else begin
        crc_value <= {crc_value[14:0], 1'b0};
      end
    end
  end

endmodule

`default_nettype wire

// ==== usb_tx_pkg.sv ====
// ****************************************
// Shared USB full-speed transmit definitions
// PID codes are the 4-bit values sent in the low nibble
// CRC16 constants match the USB data packet polynomial
// ****************************************

`default_nettype none

package usb_tx_pkg;

  // Packet identifier
  typedef logic [3:0] pid_t;

  // Data PIDs carry payload and CRC16
  localparam pid_t PID_DATA0 = 4'b0011;
  localparam pid_t PID_DATA1 = 4'b1011;

  // Handshake PIDs, PID byte only
  localparam pid_t PID_ACK   = 4'b0010;
  localparam pid_t PID_NAK   = 4'b1010;
  localparam pid_t PID_STALL = 4'b1110;

  // Sync pattern, LSB first on the line
  localparam logic [7:0] SYNC_BYTE = 8'h80;

  // CRC16 generator
  localparam logic [15:0] CRC16_POLY = 16'h8005;
  localparam logic [15:0] CRC16_INIT = 16'hFFFF;

  // Line rules
  localparam int STUFF_LIMIT  = 6;
  localparam int EOP_SE0_BITS = 2;

  // Line-state counter widths
  localparam int ONES_CNT_W = $clog2(STUFF_LIMIT + 1);
  localparam int SE0_CNT_W  = $clog2(EOP_SE0_BITS + 1);

  // True for packets that carry payload and CRC16
  function automatic logic pid_has_data(input pid_t pid_val);
    return (pid_val == PID_DATA0) || (pid_val == PID_DATA1);
  endfunction

endpackage

`default_nettype wire
